// ==== level_display.f ====
hdl/matrix_pkg.sv
hdl/regs_pkg.sv
hdl/level_regs.sv
hdl/level_glyph_rom.sv
hdl/matrix_scan.sv
hdl/level_display.sv
dv/level_display_assert.sv
dv/level_display_tb.sv

// ==== Makefile ====
# Verilator build and run for the level display testbench

VERILATOR ?= verilator
TOP       ?= level_display_tb
FILELIST  ?= level_display.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the simulator exits non-zero on $fatal
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/level_display_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module level_display_tb;
    import matrix_pkg::*;
    import regs_pkg::*;

    localparam int    scan_div     = 4;
    localparam temp_t thresh_reset = 8'd80;
    localparam int    n_iter       = 40;
    localparam int    frame_cycles = matrix_rows * scan_div;
    localparam int    bus_budget   = 80;    // about ten transfers with stalls
    localparam int    cycle_limit  = n_iter * (bus_budget + 3 * frame_cycles) + 2000;

    logic                    clk;
    logic                    rst;
    logic [axi_addr_w-1:0]   s_awaddr;
    logic                    s_awvalid;
    logic                    s_awready;
    logic [axi_data_w-1:0]   s_wdata;
    logic [axi_data_w/8-1:0] s_wstrb;
    logic                    s_wvalid;
    logic                    s_wready;
    resp_t                   s_bresp;
    logic                    s_bvalid;
    logic                    s_bready;
    logic [axi_addr_w-1:0]   s_araddr;
    logic                    s_arvalid;
    logic                    s_arready;
    logic [axi_data_w-1:0]   s_rdata;
    resp_t                   s_rresp;
    logic                    s_rvalid;
    logic                    s_rready;
    col_bits_t               row;
    col_bits_t               col_g;
    col_bits_t               col_r;

    logic [31:0] rng;
    int          cycles = 0;
    int          wr_accepts = 0;
    int          rd_accepts = 0;
    int          scan_ticks = 0;   // clock edges since reset release
    int          accept_row = 0;   // row index expected in the status word

    // register model
    logic   m_run;
    level_t m_level;
    temp_t  m_temp;
    temp_t  m_thresh;

    level_display #(
        .scan_div     (scan_div),
        .thresh_reset (thresh_reset)
    ) uut (
        .clk (clk), .rst (rst),
        .s_awaddr (s_awaddr), .s_awvalid (s_awvalid), .s_awready (s_awready),
        .s_wdata (s_wdata), .s_wstrb (s_wstrb), .s_wvalid (s_wvalid), .s_wready (s_wready),
        .s_bresp (s_bresp), .s_bvalid (s_bvalid), .s_bready (s_bready),
        .s_araddr (s_araddr), .s_arvalid (s_arvalid), .s_arready (s_arready),
        .s_rdata (s_rdata), .s_rresp (s_rresp), .s_rvalid (s_rvalid), .s_rready (s_rready),
        .row (row), .col_g (col_g), .col_r (col_r)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
            fail_run("timeout: the run went past its cycle limit");
    end

    // handshakes and scan ticks as the DUT sees them at the edge
    always @(posedge clk)
    begin
        if (s_awvalid && s_awready && s_wvalid && s_wready)
            wr_accepts <= wr_accepts + 1;
        if (s_arvalid && s_arready)
            rd_accepts <= rd_accepts + 1;
        if (rst)
            scan_ticks <= 0;
        else
            scan_ticks <= scan_ticks + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic int next_stall();
        logic [31:0] v;
        v = next_rand();
        return int'(v[29:28]);  // 0..3 cycles
    endfunction

    // glyph table, row 0 in the top byte
    function automatic col_bits_t model_glyph(input level_t lvl, input row_idx_t r);
        logic [63:0] pic;
        case (lvl)
            4'd0:    pic = 64'h0000_183c_3c18_0000;
            4'd1:    pic = 64'h0000_387c_7c38_0000;
            4'd2:    pic = 64'h0000_3c7e_7e3c_0000;
            4'd3:    pic = 64'h003c_7e7e_7e7e_3c00;
            4'd4:    pic = 64'h3c7e_ffff_ffff_7e3c;
            4'd5:    pic = 64'hffff_ffff_ffff_ffff;
            4'd6:    pic = 64'hc3e3_f1e3_c7e7_f7fb;
            default: pic = '0;
        endcase
        return pic[63 - 8 * int'(r) -: 8];
    endfunction

    function automatic int row_index(input col_bits_t r);
        int hits;
        int found;
        hits  = 0;
        found = -1;
        for (int i = 0; i < matrix_rows; i++)
        begin
            if (!r[i])
            begin
                hits++;
                found = i;
            end
        end
        return (hits == 1) ? found : -1;
    endfunction

    task automatic check_cols(input col_bits_t got, input col_bits_t exp, input string what);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %02h expected %02h",
                               $time, what, got, exp));
    endtask

    task automatic check_resp(input resp_t got, input resp_t exp, input string what);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s resp got %0d expected %0d",
                               $time, what, got, exp));
    endtask

    task automatic check_word(input logic [axi_data_w-1:0] got,
                              input logic [axi_data_w-1:0] exp, input string what);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %08h expected %08h",
                               $time, what, got, exp));
    endtask

    task automatic axi_write(input logic [axi_addr_w-1:0] addr, input logic [axi_data_w-1:0] data,
                             input logic [axi_data_w/8-1:0] strb, output resp_t resp);
        int stall;
        int accepts;
        @(negedge clk);
        accepts   = wr_accepts;
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = strb;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        do
            @(negedge clk);
        while (!s_bvalid);      // bvalid follows acceptance by one cycle
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        if (wr_accepts != accepts + 1)
            fail_run("write address and data were not taken together in one handshake");
        stall     = next_stall();
        repeat (stall) @(negedge clk);
        if (!s_bvalid)
            fail_run("write response dropped before bready");
        resp     = s_bresp;     // must still hold after the stall
        s_bready = 1'b1;
        @(negedge clk);
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [axi_addr_w-1:0] addr,
                            output logic [axi_data_w-1:0] data, output resp_t resp);
        int stall;
        int accepts;
        @(negedge clk);
        accepts   = rd_accepts;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        do
            @(negedge clk);
        while (!s_rvalid);
        s_arvalid  = 1'b0;
        accept_row = ((scan_ticks - 1) / scan_div) % matrix_rows;  // row_sel before that edge
        if (rd_accepts != accepts + 1)
            fail_run("read address was not taken in exactly one handshake");
        stall     = next_stall();
        repeat (stall) @(negedge clk);
        if (!s_rvalid)
            fail_run("read response dropped before rready");
        data     = s_rdata;     // must still hold after the stall
        resp     = s_rresp;
        s_rready = 1'b1;
        @(negedge clk);
        s_rready = 1'b0;
    endtask

    task automatic write_ok(input logic [axi_addr_w-1:0] addr, input logic [axi_data_w-1:0] data);
        resp_t resp;
        axi_write(addr, data, '1, resp);
        check_resp(resp, resp_okay, "register write");
    endtask

    task automatic read_check(input logic [axi_addr_w-1:0] addr,
                              input logic [axi_data_w-1:0] exp, input string what);
        logic [axi_data_w-1:0] data;
        logic [axi_data_w-1:0] exp_word;
        resp_t                 resp;
        axi_read(addr, data, resp);
        check_resp(resp, resp_okay, what);
        exp_word = exp;
        if (addr == status_off)
            exp_word[status_row_lsb +: $bits(row_idx_t)] = row_idx_t'(accept_row);
        check_word(data, exp_word, what);
    endtask

    task automatic read_all_check();
        read_check(ctrl_off, 32'(m_run), "ctrl readback");
        read_check(level_off, 32'(m_level), "level readback");
        read_check(temp_off, 32'(m_temp), "temp readback");
        read_check(thresh_off, 32'(m_thresh), "thresh readback");
        read_check(status_off, 32'(m_temp > m_thresh), "status alarm");
    endtask

    task automatic check_frame();
        int        idx;
        int        prev_idx;
        int        steps;
        col_bits_t exp_g;
        prev_idx = -1;
        steps    = 0;
        repeat (frame_cycles + scan_div)
        begin
            @(negedge clk);
            idx = row_index(row);
            if (idx < 0)
                fail_run($sformatf("row drive %08b at %0t is not one active-low row",
                                   row, $time));
            if (idx != prev_idx)
            begin
                if (prev_idx >= 0 && idx != (prev_idx + 1) % matrix_rows)
                    fail_run($sformatf("mismatch at %0t: row order got %0d expected %0d",
                                       $time, idx, (prev_idx + 1) % matrix_rows));
                prev_idx = idx;
                steps++;
            end
            exp_g = m_run ? model_glyph(m_level, row_idx_t'(idx)) : '0;
            check_cols(col_g, exp_g, "green columns");
            check_cols(col_r, (m_temp > m_thresh) ? exp_g : '0, "red columns");
        end
        if (steps < matrix_rows)
            fail_run("row scan stalled: fewer than eight rows strobed in a frame");
    endtask

    initial
    begin
        logic [31:0]           r;
        logic [axi_data_w-1:0] data;
        resp_t                 resp;
        int                    first_row;
        rst       = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        rng       = 32'he1c6;
        m_run     = 1'b0;
        m_level   = '0;
        m_temp    = '0;
        m_thresh  = thresh_reset;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_cols(row, '1, "row after reset");
        check_cols(col_g, '0, "green after reset");
        check_cols(col_r, '0, "red after reset");

        // first row strobe scan_div+1 cycles after release
        first_row = 1;
        while (row === '1 && first_row <= scan_div + 1)
        begin
            @(negedge clk);
            first_row++;
        end
        if (first_row != scan_div + 1)
            fail_run($sformatf("mismatch at %0t: first row after %0d cycles expected %0d",
                               $time, first_row, scan_div + 1));
        read_all_check();

        // error responses leave every register alone
        write_ok(level_off, 32'd2);
        m_level = 4'd2;
        axi_write(status_off, 32'hffff_ffff, '1, resp);
        check_resp(resp, resp_slverr, "status write");
        axi_write(5'h14, 32'hffff_ffff, '1, resp);
        check_resp(resp, resp_slverr, "unmapped write");
        axi_write(level_off, 32'h0000_000f, 4'b1110, resp);
        check_resp(resp, resp_okay, "strobe-off write");
        read_all_check();
        axi_read(5'h18, data, resp);
        check_resp(resp, resp_slverr, "unmapped read");
        check_word(data, '0, "unmapped read data");

        for (int it = 0; it < n_iter; it++)
        begin
            r        = next_rand();
            m_level  = r[19:16];
            m_run    = (it % 4 != 3);   // every fourth pass with the display off
            r        = next_rand();
            m_temp   = r[23:16];
            m_thresh = r[31:24];
            if (r[3:0] == 4'd0)
                m_thresh = m_temp;
            write_ok(ctrl_off, 32'(m_run));
            write_ok(level_off, 32'(m_level));
            write_ok(temp_off, 32'(m_temp));
            write_ok(thresh_off, 32'(m_thresh));
            read_all_check();
            repeat (2 * frame_cycles) @(negedge clk);
            check_frame();
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/level_display_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module level_display_assert (
    input logic                            clk,
    input logic                            rst,
    input logic                            alarm,
    input matrix_pkg::col_bits_t           row,
    input matrix_pkg::col_bits_t           col_g,
    input matrix_pkg::col_bits_t           col_r,
    input logic                            s_bvalid,
    input logic                            s_bready,
    input regs_pkg::resp_t                 s_bresp,
    input logic                            s_rvalid,
    input logic                            s_rready,
    input logic [regs_pkg::axi_data_w-1:0] s_rdata,
    input regs_pkg::resp_t                 s_rresp
);

    // one row low at a time, or none
    row_one_hot: assert property (@(posedge clk) disable iff (rst)
        ($onehot(~row) || (&row)))
        else $error("row drive has more than one active row");

    red_needs_green: assert property (@(posedge clk) disable iff (rst)
        (col_g == '0) |-> (col_r == '0))
        else $error("red columns lit over dark green");

    // col_r is registered from the alarm of the cycle before
    red_needs_alarm: assert property (@(posedge clk) disable iff (rst)
        (col_r != '0) |-> $past(alarm))
        else $error("red columns lit without alarm");

    b_hold: assert property (@(posedge clk) disable iff (rst)
        (s_bvalid && !s_bready) |=> (s_bvalid && $stable(s_bresp)))
        else $error("write response dropped or changed before bready");

    r_hold: assert property (@(posedge clk) disable iff (rst)
        (s_rvalid && !s_rready) |=> (s_rvalid && $stable(s_rdata) && $stable(s_rresp)))
        else $error("read response dropped or changed before rready");

endmodule

bind level_display level_display_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .alarm    (alarm),
    .row      (row),
    .col_g    (col_g),
    .col_r    (col_r),
    .s_bvalid (s_bvalid),
    .s_bready (s_bready),
    .s_bresp  (s_bresp),
    .s_rvalid (s_rvalid),
    .s_rready (s_rready),
    .s_rdata  (s_rdata),
    .s_rresp  (s_rresp)
);

`default_nettype wire

// ==== hdl/level_display.sv ====
`timescale 1ns/100ps
`default_nettype none

module level_display #(
    parameter int              scan_div     = 4,
    parameter regs_pkg::temp_t thresh_reset = 8'd80
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [regs_pkg::axi_addr_w-1:0]   s_awaddr,
    input  logic                              s_awvalid,
    output logic                              s_awready,
    input  logic [regs_pkg::axi_data_w-1:0]   s_wdata,
    input  logic [regs_pkg::axi_data_w/8-1:0] s_wstrb,
    input  logic                              s_wvalid,
    output logic                              s_wready,
    output regs_pkg::resp_t                   s_bresp,
    output logic                              s_bvalid,
    input  logic                              s_bready,
    input  logic [regs_pkg::axi_addr_w-1:0]   s_araddr,
    input  logic                              s_arvalid,
    output logic                              s_arready,
    output logic [regs_pkg::axi_data_w-1:0]   s_rdata,
    output regs_pkg::resp_t                   s_rresp,
    output logic                              s_rvalid,
    input  logic                              s_rready,
    output matrix_pkg::col_bits_t             row,
    output matrix_pkg::col_bits_t             col_g,
    output matrix_pkg::col_bits_t             col_r
);
    import matrix_pkg::*;

    logic      run_en;
    logic      alarm;
    level_t    level;
    row_idx_t  row_sel;
    col_bits_t glyph_cols;

    level_regs #(
        .thresh_reset (thresh_reset)
    ) u_regs (
        .clk       (clk),
        .rst       (rst),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .row_sel   (row_sel),
        .run_en    (run_en),
        .level     (level),
        .alarm     (alarm)
    );

    level_glyph_rom u_rom (
        .level      (level),
        .row_sel    (row_sel),
        .glyph_cols (glyph_cols)
    );

    matrix_scan #(
        .scan_div (scan_div)
    ) u_scan (
        .clk        (clk),
        .rst        (rst),
        .run_en     (run_en),
        .alarm      (alarm),
        .glyph_cols (glyph_cols),
        .row_sel    (row_sel),
        .row        (row),
        .col_g      (col_g),
        .col_r      (col_r)
    );

endmodule

`default_nettype wire

// ==== hdl/matrix_scan.sv ====
`timescale 1ns/100ps
`default_nettype none

module matrix_scan #(
    parameter int scan_div = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run_en,
    input  logic                  alarm,
    input  matrix_pkg::col_bits_t glyph_cols,
    output matrix_pkg::row_idx_t  row_sel,
    output matrix_pkg::col_bits_t row,
    output matrix_pkg::col_bits_t col_g,
    output matrix_pkg::col_bits_t col_r
);
    import matrix_pkg::*;

    localparam int               div_w    = $clog2(scan_div + 1);
    localparam logic [div_w-1:0] div_last = div_w'(scan_div - 1);

    logic [div_w-1:0] div_cnt;
    logic             row_step;
    logic             scan_live;  // outputs stay dark until the first step
    col_bits_t        col_next;

    assign row_step = (div_cnt == div_last);
    assign col_next = run_en ? glyph_cols : '0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt   <= '0;
            row_sel   <= '0;
            scan_live <= 1'b0;
        end
        else if (row_step)
        begin
            div_cnt   <= '0;
            scan_live <= 1'b1;
            if (row_sel == row_idx_t'(matrix_rows - 1))
                row_sel <= '0;
            else
                row_sel <= row_sel + 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // row and colours move together, one cycle after row_sel
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row   <= '1;    // no row driven
            col_g <= '0;
            col_r <= '0;
        end
        else if (scan_live)
        begin
            row   <= ~(col_bits_t'(1) << row_sel);  // active low
            col_g <= col_next;
            col_r <= alarm ? col_next : '0;         // red over green gives amber
        end
    end

endmodule

`default_nettype wire

// ==== hdl/level_glyph_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

module level_glyph_rom (
    input  matrix_pkg::level_t    level,
    input  matrix_pkg::row_idx_t  row_sel,
    output matrix_pkg::col_bits_t glyph_cols
);
    import matrix_pkg::*;

    logic [1:0] ring;   // distance from the middle row pair
    col_bits_t  blob;
    col_bits_t  flame;

    // rows 3,4 -> 0 ... rows 0,7 -> 3
    assign ring = row_sel[2] ? row_sel[1:0] : ~row_sel[1:0];

    always_comb
    begin
        blob = '0;
        case (level)
            4'd0: if (ring == 2'd0) blob = 8'b0011_1100;
                  else if (ring == 2'd1) blob = 8'b0001_1000;
            4'd1: if (ring == 2'd0) blob = 8'b0111_1100;
                  else if (ring == 2'd1) blob = 8'b0011_1000;
            4'd2: if (ring == 2'd0) blob = 8'b0111_1110;
                  else if (ring == 2'd1) blob = 8'b0011_1100;
            4'd3: if (ring <= 2'd1) blob = 8'b0111_1110;
                  else if (ring == 2'd2) blob = 8'b0011_1100;
            4'd4:
            begin
                case (ring)
                    2'd0, 2'd1: blob = 8'b1111_1111;
                    2'd2:       blob = 8'b0111_1110;
                    default:    blob = 8'b0011_1100;  // top and bottom rows
                endcase
            end
            default: blob = '0;
        endcase
    end

    // jagged flame, not symmetric
    always_comb
    begin
        case (row_sel)
            3'd0:    flame = 8'b1100_0011;
            3'd1:    flame = 8'b1110_0011;
            3'd2:    flame = 8'b1111_0001;
            3'd3:    flame = 8'b1110_0011;
            3'd4:    flame = 8'b1100_0111;
            3'd5:    flame = 8'b1110_0111;
            3'd6:    flame = 8'b1111_0111;
            default: flame = 8'b1111_1011;
        endcase
    end

    always_comb
    begin
        if (level > max_level)
            glyph_cols = '0;        // reserved codes stay blank
        else if (level == level_full)
            glyph_cols = '1;
        else if (level == level_flame)
            glyph_cols = flame;
        else
            glyph_cols = blob;
    end

endmodule

`default_nettype wire

// ==== hdl/level_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module level_regs #(
    parameter regs_pkg::temp_t thresh_reset = 8'd80
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [regs_pkg::axi_addr_w-1:0]   s_awaddr,
    input  logic                              s_awvalid,
    output logic                              s_awready,
    input  logic [regs_pkg::axi_data_w-1:0]   s_wdata,
    input  logic [regs_pkg::axi_data_w/8-1:0] s_wstrb,
    input  logic                              s_wvalid,
    output logic                              s_wready,
    output regs_pkg::resp_t                   s_bresp,
    output logic                              s_bvalid,
    input  logic                              s_bready,
    input  logic [regs_pkg::axi_addr_w-1:0]   s_araddr,
    input  logic                              s_arvalid,
    output logic                              s_arready,
    output logic [regs_pkg::axi_data_w-1:0]   s_rdata,
    output regs_pkg::resp_t                   s_rresp,
    output logic                              s_rvalid,
    input  logic                              s_rready,
    input  matrix_pkg::row_idx_t              row_sel,
    output logic                              run_en,
    output matrix_pkg::level_t                level,
    output logic                              alarm
);
    import regs_pkg::*;
    import matrix_pkg::*;

    temp_t                 temp;
    temp_t                 thresh;
    logic                  wr_fire;
    logic                  wr_mapped;
    logic                  rd_fire;
    logic                  rd_mapped;
    logic [axi_data_w-1:0] rd_word;

    // address and data taken together, one response in flight
    assign wr_fire   = s_awvalid && s_wvalid && !s_bvalid;
    assign s_awready = wr_fire;
    assign s_wready  = wr_fire;

    assign rd_fire   = s_arvalid && !s_rvalid;
    assign s_arready = !s_rvalid;

    always_comb
    begin
        case (s_awaddr)
            ctrl_off, level_off, temp_off, thresh_off: wr_mapped = 1'b1;
            default: wr_mapped = 1'b0;  // status and holes
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            run_en <= 1'b0;
            level  <= '0;
            temp   <= '0;
            thresh <= thresh_reset;
        end
        else if (wr_fire && wr_mapped && s_wstrb[0])
        begin
            case (s_awaddr)
                ctrl_off:   run_en <= s_wdata[ctrl_run_bit];
                level_off:  level  <= s_wdata[level_lsb +: $bits(level_t)];
                temp_off:   temp   <= s_wdata[temp_lsb +: $bits(temp_t)];
                thresh_off: thresh <= s_wdata[thresh_lsb +: $bits(temp_t)];
                default:    run_en <= run_en;
            endcase
        end
    end

    // over-temperature compare, one cycle behind the registers
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            alarm <= 1'b0;
        else
            alarm <= (temp > thresh);
    end

    always_comb
    begin
        rd_word   = '0;
        rd_mapped = 1'b1;
        case (s_araddr)
            ctrl_off:   rd_word[ctrl_run_bit] = run_en;
            level_off:  rd_word[level_lsb +: $bits(level_t)] = level;
            temp_off:   rd_word[temp_lsb +: $bits(temp_t)] = temp;
            thresh_off: rd_word[thresh_lsb +: $bits(temp_t)] = thresh;
            status_off:
            begin
                rd_word[status_alarm_bit] = alarm;
                rd_word[status_row_lsb +: $bits(row_idx_t)] = row_sel;
            end
            default:    rd_mapped = 1'b0;  // zero data, slverr
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s_bvalid <= 1'b0;
            s_rvalid <= 1'b0;
        end
        else
        begin
            if (wr_fire)
                s_bvalid <= 1'b1;
            else if (s_bready)
                s_bvalid <= 1'b0;

            if (rd_fire)
                s_rvalid <= 1'b1;
            else if (s_rready)
                s_rvalid <= 1'b0;
        end
    end

    // response payload, held while valid waits for ready
    always_ff @(posedge clk)
    begin
        if (wr_fire)
            s_bresp <= wr_mapped ? resp_okay : resp_slverr;
        if (rd_fire)
        begin
            s_rdata <= rd_word;
            s_rresp <= rd_mapped ? resp_okay : resp_slverr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/regs_pkg.sv ====
`default_nettype none

package regs_pkg;

    localparam int axi_addr_w = 5;
    localparam int axi_data_w = 32;

    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay   = 2'd0;
    localparam resp_t resp_slverr = 2'd2;

    // register offsets
    localparam logic [axi_addr_w-1:0] ctrl_off   = 5'h00;
    localparam logic [axi_addr_w-1:0] level_off  = 5'h04;
    localparam logic [axi_addr_w-1:0] temp_off   = 5'h08;
    localparam logic [axi_addr_w-1:0] thresh_off = 5'h0c;
    localparam logic [axi_addr_w-1:0] status_off = 5'h10;  // read only

    // field positions
    localparam int ctrl_run_bit     = 0;
    localparam int level_lsb        = 0;
    localparam int temp_lsb         = 0;
    localparam int thresh_lsb       = 0;
    localparam int status_alarm_bit = 0;
    localparam int status_row_lsb   = 4;

    // unsigned temperature reading
    typedef logic [7:0] temp_t;

endpackage

`default_nettype wire

// ==== hdl/matrix_pkg.sv ====
`default_nettype none

package matrix_pkg;

    // dot matrix geometry
    localparam int matrix_rows = 8;
    localparam int matrix_cols = 8;

    typedef logic [$clog2(matrix_rows)-1:0] row_idx_t;

    // one row of dots, bit 7 is the leftmost
    typedef logic [matrix_cols-1:0] col_bits_t;

    typedef logic [3:0] level_t;

    // levels 0..4 are the growing blob
    localparam level_t level_full  = 4'd5;
    localparam level_t level_flame = 4'd6;

    // codes above this show a blank matrix
    localparam level_t max_level = level_flame;

endpackage

`default_nettype wire
